// File: include/memStageModel.svh
`ifndef MEM_STAGE_MODEL_SVH
`define MEM_STAGE_MODEL_SVH

function automatic logic readsMemory(instrT instr);
    return instr.i.opcode inside {opLb, opLbu, opLh, opLhu, opLw};
endfunction

function automatic logic writesMemory(instrT instr);
    return instr.i.opcode inside {opSb, opSh, opSw};
endfunction

// AdEL or AdES on the data address, zero for non-memory instructions
function automatic logic dataAddrMisaligned(instrT instr, logic [dataW-1:0] addr);
    if (instr.i.opcode inside {opLh, opLhu, opSh}) return addr[0];
    if (instr.i.opcode inside {opLw, opSw}) return addr[1:0] != 2'b00;
    return 1'b0;
endfunction

// raw enables before exception gating
function automatic logic [laneN-1:0] byteEnables(instrT instr, logic [dataW-1:0] addr);
    case (instr.i.opcode)
        opSb:    return laneN'(1) << addr[1:0];
        opSh:    return addr[1] ? 4'b1100 : 4'b0011;
        opSw:    return '1;
        default: return '0;
    endcase
endfunction

// store operand copied into every lane, stores only
function automatic logic [dataW-1:0] replicatedStore(instrT instr, logic [dataW-1:0] val);
    if (instr.i.opcode == opSb) return {4{val[7:0]}};
    if (instr.i.opcode == opSh) return {2{val[15:0]}};
    return val;
endfunction

function automatic logic [dataW-1:0] writebackResult(instrT instr, logic [dataW-1:0] addr,
                                                     logic [dataW-1:0] aluout,
                                                     logic [dataW-1:0] rdata);
    logic [7:0]  b;
    logic [15:0] h;
    b = rdata[8*addr[1:0] +: 8];
    h = addr[1] ? rdata[31:16] : rdata[15:0];
    case (instr.i.opcode)
        opLb:    return {{24{b[7]}}, b};
        opLbu:   return {24'b0, b};
        opLh:    return {{16{h[15]}}, h};
        opLhu:   return {16'b0, h};
        opLw:    return rdata;
        default: return aluout;
    endcase
endfunction

// expected exceptW, with code and BadVAddr left zero when nothing is taken
function automatic logic expectedException(logic valid, instrT instr, logic [dataW-1:0] pc,
                                           logic [dataW-1:0] addr, logic overflow,
                                           output logic [excCodeW-1:0] code,
                                           output logic [dataW-1:0] badAddr);
    logic isSpecial;
    isSpecial = instr.r.opcode == opSpecial;
    code      = '0;
    badAddr   = '0;
    if (!valid) return 1'b0;
    if (pc[1:0] != 2'b00) begin
        code    = excAdel;
        badAddr = pc;
    end else if (isSpecial && instr.r.funct == fnSyscall) begin
        code = excSys;
    end else if (isSpecial && instr.r.funct == fnBreak) begin
        code = excBp;
    end else if (overflow) begin
        code = excOv;
    end else if (dataAddrMisaligned(instr, addr)) begin
        code    = readsMemory(instr) ? excAdel : excAdes;
        badAddr = addr;
    end
    return code != '0;
endfunction

`endif

// File: bench/memStageTb.sv
`timescale 1ns/1ns

module memStageTb
    import memStagePkg::*;
();

    `include "memStageModel.svh"

    localparam logic [5:0] fnAdd = 6'h20;

    logic                clk;
    logic                rstN_i;
    logic                validM_i;
    logic [dataW-1:0]    instrM_i;
    logic [dataW-1:0]    pcM_i;
    logic [dataW-1:0]    aluoutM_i;
    logic [dataW-1:0]    rtValueM_i;
    logic [regAddrW-1:0] writeregM_i;
    logic                regwriteM_i;
    logic                overflowM_i;
    logic [dataW-1:0]    memRdata_i;
    logic                memEn_o;
    logic [dataW-1:0]    memAddr_o;
    logic [laneN-1:0]    memWen_o;
    logic [dataW-1:0]    memWdata_o;
    logic [dataW-1:0]    resultW_o;
    logic [regAddrW-1:0] writeregW_o;
    logic                regwriteW_o;
    logic                exceptW_o;
    logic [excCodeW-1:0] excCodeW_o;
    logic [dataW-1:0]    epcW_o;
    logic [dataW-1:0]    badVaddrW_o;

    logic [15:0] lfsr = 16'd60082;
    int          checkCount = 0;
    int          errorCount = 0;
    int          testCount = 0;
    int          excSeen = 0;
    int          memSeen = 0;

    memStage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rstN_i = 1'b0;
        repeat (3) @(posedge clk);
        #2 rstN_i = 1'b1;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [5:0] memOpcode(input logic [2:0] sel);
        case (sel)
            3'd0:    return opLb;
            3'd1:    return opLbu;
            3'd2:    return opLh;
            3'd3:    return opLhu;
            3'd4:    return opLw;
            3'd5:    return opSb;
            3'd6:    return opSh;
            default: return opSw;
        endcase
    endfunction

    task automatic compareValue(input string sigName, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, sigName, expected, actual);
        end
    endtask

    // every W register is held clear while reset is low
    task automatic checkResetState();
        compareValue("regwriteW_o", 1'b0, regwriteW_o);
        compareValue("exceptW_o", 1'b0, exceptW_o);
        compareValue("resultW_o", '0, resultW_o);
        compareValue("writeregW_o", '0, writeregW_o);
        compareValue("excCodeW_o", '0, excCodeW_o);
        compareValue("epcW_o", '0, epcW_o);
        compareValue("badVaddrW_o", '0, badVaddrW_o);
    endtask

    // one instruction through M and W, entered at posedge+1
    task automatic runCycle(input logic forceInvalid);
        logic [4:0]          sel;
        instrT               instr;
        logic                expExc;
        logic                expMemEn;
        logic [excCodeW-1:0] expCode;
        logic [dataW-1:0]    expBad;
        logic [dataW-1:0]    expResult;
        #1;
        sel   = 5'(lfsrBits(5));
        instr = lfsrBits(32);
        if (sel < 5'd24) begin
            instr.i.opcode = memOpcode(sel[2:0]);
        end else begin
            instr.r.opcode = opSpecial;
            instr.r.funct  = (sel == 5'd24) ? fnSyscall : (sel == 5'd25) ? fnBreak : fnAdd;
        end
        instrM_i  = instr;
        aluoutM_i = lfsrBits(32);
        if (lfsrBits(2) != 0) aluoutM_i[1:0] = 2'b00; // mostly aligned
        pcM_i = {30'(lfsrBits(30)), 2'b00};
        if (lfsrBits(4) == 0) pcM_i[1:0] = lfsrBits(1) ? 2'b10 : 2'b01;
        overflowM_i = lfsrBits(5) == 0;
        memRdata_i  = lfsrBits(32);
        rtValueM_i  = lfsrBits(32);
        regwriteM_i = lfsrBits(1) != 0;
        writeregM_i = regAddrW'(lfsrBits(5));
        validM_i    = forceInvalid ? 1'b0 : (lfsrBits(3) != 0);

        expExc    = expectedException(validM_i, instr, pcM_i, aluoutM_i, overflowM_i,
                                      expCode, expBad);
        expMemEn  = validM_i && (readsMemory(instr) || writesMemory(instr)) && !expExc;
        expResult = writebackResult(instr, aluoutM_i, aluoutM_i, memRdata_i);
        excSeen  += expExc;
        memSeen  += expMemEn;

        #20; // combinational outputs settled
        compareValue("memEn_o", expMemEn, memEn_o);
        compareValue("memAddr_o", aluoutM_i, memAddr_o);
        compareValue("memWen_o", expMemEn ? byteEnables(instr, aluoutM_i) : '0, memWen_o);
        if (writesMemory(instr)) begin
            compareValue("memWdata_o", replicatedStore(instr, rtValueM_i), memWdata_o);
        end

        @(posedge clk);
        #1;
        compareValue("resultW_o", expResult, resultW_o);
        compareValue("writeregW_o", writeregM_i, writeregW_o);
        compareValue("regwriteW_o", validM_i && regwriteM_i && !expExc, regwriteW_o);
        compareValue("exceptW_o", expExc, exceptW_o);
        compareValue("excCodeW_o", expCode, excCodeW_o);
        compareValue("epcW_o", pcM_i, epcW_o);
        compareValue("badVaddrW_o", expBad, badVaddrW_o);
    endtask

    initial begin
        int waitCycles;
        int errorsBefore;
        validM_i    = 1'b0;
        instrM_i    = '0;
        pcM_i       = '0;
        aluoutM_i   = '0;
        rtValueM_i  = '0;
        writeregM_i = '0;
        regwriteM_i = 1'b0;
        overflowM_i = 1'b0;
        memRdata_i  = '0;

        errorsBefore = errorCount;
        waitCycles   = 0;
        while (rstN_i !== 1'b1 && waitCycles < 20) begin
            @(posedge clk);
            #1;
            waitCycles++;
            if (rstN_i !== 1'b1) begin
                checkResetState();
            end
        end
        if (rstN_i !== 1'b1) begin
            $display("reset was never released within 20 cycles");
            $display("Simulation failed");
            $finish;
        end else begin
            testCount++;
            $display("test reset: %0d errors", errorCount - errorsBefore);

            errorsBefore = errorCount;
            repeat (400) runCycle(1'b0);
            testCount++;
            $display("test random mix: 400 cycles, %0d accesses, %0d exceptions, %0d errors",
                     memSeen, excSeen, errorCount - errorsBefore);

            errorsBefore = errorCount;
            repeat (60) runCycle(1'b1);
            testCount++;
            $display("test valid low: 60 cycles, %0d errors", errorCount - errorsBefore);

            $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

// File: logic/exceptDetect.sv
`timescale 1ns/1ns

module exceptDetect
    import memStagePkg::*;
(
    input  instrT               instr_i,
    input  logic [dataW-1:0]    pc_i,
    input  logic                overflow_i,
    output logic                insnExc_o,
    output logic [excCodeW-1:0] insnCode_o,
    output logic [dataW-1:0]    insnBadAddr_o
);

    logic pcMis;
    logic isSpecial;
    logic isSys;
    logic isBrk;

    assign pcMis     = pc_i[1:0] != 2'b00;       // fetch address error
    assign isSpecial = instr_i.r.opcode == opSpecial;
    assign isSys     = isSpecial && instr_i.r.funct == fnSyscall;
    assign isBrk     = isSpecial && instr_i.r.funct == fnBreak;

    assign insnExc_o = pcMis | isSys | isBrk | overflow_i;

    // fetch error first, then the instruction's own traps
    always_comb begin
        if (pcMis) begin
            insnCode_o = excAdel;
        end else if (isSys) begin
            insnCode_o = excSys;
        end else if (isBrk) begin
            insnCode_o = excBp;
        end else if (overflow_i) begin
            insnCode_o = excOv;
        end else begin
            insnCode_o = '0;
        end
    end

    assign insnBadAddr_o = pcMis ? pc_i : '0; // bad PC goes to BadVAddr

    knownCode: assert #0 (!insnExc_o ||
                          insnCode_o inside {excAdel, excSys, excBp, excOv});

endmodule

// File: logic/memCommit.sv
`timescale 1ns/1ns

module memCommit
    import memStagePkg::*;
(
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                valid_i,
    input  logic [dataW-1:0]    pc_i,
    input  logic [dataW-1:0]    aluout_i,
    input  logic [regAddrW-1:0] writereg_i,
    input  logic                regwrite_i,
    input  logic                insnExc_i,
    input  logic [excCodeW-1:0] insnCode_i,
    input  logic [dataW-1:0]    insnBadAddr_i,
    memLaneIf.dst               lane,
    output logic                memEn_o,
    output logic [laneN-1:0]    memWen_o,
    output logic [dataW-1:0]    memWdata_o,
    output logic [dataW-1:0]    resultW_o,
    output logic [regAddrW-1:0] writeregW_o,
    output logic                regwriteW_o,
    output logic                exceptW_o,
    output logic [excCodeW-1:0] excCodeW_o,
    output logic [dataW-1:0]    epcW_o,
    output logic [dataW-1:0]    badVaddrW_o
);

    logic                anyExc;
    logic                takeExc;
    logic [excCodeW-1:0] excCode;
    logic [dataW-1:0]    badAddr;
    logic [dataW-1:0]    result;

    assign anyExc  = insnExc_i | lane.loadErr | lane.storeErr;
    assign takeExc = valid_i & anyExc;

    // instruction causes beat data address errors
    always_comb begin
        excCode = '0;
        badAddr = '0;
        if (insnExc_i) begin
            excCode = insnCode_i;
            badAddr = insnBadAddr_i; // zero unless the PC is bad
        end else if (lane.loadErr) begin
            excCode = excAdel;
            badAddr = aluout_i;
        end else if (lane.storeErr) begin
            excCode = excAdes;
            badAddr = aluout_i;
        end
    end

    // a faulting instruction never reaches memory
    assign memEn_o    = valid_i & (lane.isLoad | lane.isStore) & ~anyExc;
    assign memWen_o   = memEn_o ? lane.laneWen : '0;
    assign memWdata_o = lane.storeData;

    assign result = lane.isLoad ? lane.loadData : aluout_i;

    // M to W register
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            resultW_o   <= '0;
            writeregW_o <= '0;
            regwriteW_o <= 1'b0;
            exceptW_o   <= 1'b0;
            excCodeW_o  <= '0;
            epcW_o      <= '0;
            badVaddrW_o <= '0;
        end else begin
            resultW_o   <= result;
            writeregW_o <= writereg_i;
            regwriteW_o <= valid_i & regwrite_i & ~anyExc;
            exceptW_o   <= takeExc;
            excCodeW_o  <= takeExc ? excCode : '0;
            epcW_o      <= pc_i;
            badVaddrW_o <= takeExc ? badAddr : '0;
        end
    end

    wenNeedsEn: assert property (@(posedge clk) disable iff (!rstN_i)
        (memWen_o != '0) |-> memEn_o);

    // no access goes out for an instruction that faults
    excBlocksAccess: assert property (@(posedge clk) disable iff (!rstN_i)
        takeExc |-> !memEn_o);

endmodule

// File: logic/memLane.sv
`timescale 1ns/1ns

module memLane
    import memStagePkg::*;
(
    input  instrT            instr_i,
    input  logic [dataW-1:0] addr_i,
    input  logic [dataW-1:0] storeVal_i,
    input  logic [dataW-1:0] memRdata_i,
    memLaneIf.src            lane
);

    logic       sizeByte;
    logic       sizeHalf;
    logic       signedLd;
    logic       misaligned;
    logic [7:0] rdByte;
    logic [15:0] rdHalf;

    // opcode decode on the I-type view
    always_comb begin
        lane.isLoad  = 1'b0;
        lane.isStore = 1'b0;
        sizeByte     = 1'b0;
        sizeHalf     = 1'b0;
        signedLd     = 1'b0;
        case (instr_i.i.opcode)
            opLb: begin
                lane.isLoad = 1'b1;
                sizeByte    = 1'b1;
                signedLd    = 1'b1;
            end
            opLbu: begin
                lane.isLoad = 1'b1;
                sizeByte    = 1'b1;
            end
            opLh: begin
                lane.isLoad = 1'b1;
                sizeHalf    = 1'b1;
                signedLd    = 1'b1;
            end
            opLhu: begin
                lane.isLoad = 1'b1;
                sizeHalf    = 1'b1;
            end
            opLw:    lane.isLoad  = 1'b1;
            opSb: begin
                lane.isStore = 1'b1;
                sizeByte     = 1'b1;
            end
            opSh: begin
                lane.isStore = 1'b1;
                sizeHalf     = 1'b1;
            end
            opSw:    lane.isStore = 1'b1;
            default: ;
        endcase
    end

    // store side
    always_comb begin
        lane.laneWen = '0;
        if (lane.isStore) begin
            if (sizeByte) begin
                lane.laneWen = laneN'(1) << addr_i[1:0];
            end else if (sizeHalf) begin
                lane.laneWen = addr_i[1] ? 4'b1100 : 4'b0011; // upper or lower half
            end else begin
                lane.laneWen = '1;
            end
        end
    end

    assign lane.storeData = sizeByte ? {4{storeVal_i[7:0]}} :
                            sizeHalf ? {2{storeVal_i[15:0]}} : storeVal_i;

    // load side
    assign rdByte = memRdata_i[8*addr_i[1:0] +: 8];
    assign rdHalf = addr_i[1] ? memRdata_i[31:16] : memRdata_i[15:0];

    always_comb begin
        if (sizeByte) begin
            lane.loadData = {{(dataW-8){signedLd & rdByte[7]}}, rdByte};
        end else if (sizeHalf) begin
            lane.loadData = {{(dataW-16){signedLd & rdHalf[15]}}, rdHalf};
        end else begin
            lane.loadData = memRdata_i;
        end
    end

    // word needs both low bits clear, halfword only bit 0
    assign misaligned    = sizeHalf ? addr_i[0] : (!sizeByte && addr_i[1:0] != 2'b00);
    assign lane.loadErr  = lane.isLoad & misaligned;
    assign lane.storeErr = lane.isStore & misaligned;

    oneKind: assert #0 (!(lane.isLoad && lane.isStore));
    wenOnlyStore: assert #0 (lane.isStore || lane.laneWen == '0);

endmodule

// File: logic/memLaneIf.sv
`timescale 1ns/1ns

interface memLaneIf
    import memStagePkg::*;
();

    logic             isLoad;
    logic             isStore;
    logic [laneN-1:0] laneWen;   // raw byte enables, not yet gated
    logic [dataW-1:0] storeData; // store operand copied into lanes
    logic [dataW-1:0] loadData;  // extracted and extended read data
    logic             loadErr;   // AdEL on data address
    logic             storeErr;  // AdES on data address

    modport src (
        output isLoad, isStore, laneWen, storeData, loadData, loadErr, storeErr
    );

    modport dst (
        input isLoad, isStore, laneWen, storeData, loadData, loadErr, storeErr
    );

endinterface

// File: logic/memStage.sv
`timescale 1ns/1ns

module memStage
    import memStagePkg::*;
(
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                validM_i,
    input  logic [dataW-1:0]    instrM_i,
    input  logic [dataW-1:0]    pcM_i,
    input  logic [dataW-1:0]    aluoutM_i,
    input  logic [dataW-1:0]    rtValueM_i,
    input  logic [regAddrW-1:0] writeregM_i,
    input  logic                regwriteM_i,
    input  logic                overflowM_i,
    input  logic [dataW-1:0]    memRdata_i,
    output logic                memEn_o,
    output logic [dataW-1:0]    memAddr_o,
    output logic [laneN-1:0]    memWen_o,
    output logic [dataW-1:0]    memWdata_o,
    output logic [dataW-1:0]    resultW_o,
    output logic [regAddrW-1:0] writeregW_o,
    output logic                regwriteW_o,
    output logic                exceptW_o,
    output logic [excCodeW-1:0] excCodeW_o,
    output logic [dataW-1:0]    epcW_o,
    output logic [dataW-1:0]    badVaddrW_o
);

    logic                insnExc;
    logic [excCodeW-1:0] insnCode;
    logic [dataW-1:0]    insnBadAddr;

    memLaneIf laneBus ();

    assign memAddr_o = aluoutM_i; // data address straight from execute

    memLane memLane_i (
        .instr_i    (instrM_i),
        .addr_i     (aluoutM_i),
        .storeVal_i (rtValueM_i),
        .memRdata_i (memRdata_i),
        .lane       (laneBus.src)
    );

    exceptDetect exceptDetect_i (
        .instr_i       (instrM_i),
        .pc_i          (pcM_i),
        .overflow_i    (overflowM_i),
        .insnExc_o     (insnExc),
        .insnCode_o    (insnCode),
        .insnBadAddr_o (insnBadAddr)
    );

    memCommit memCommit_i (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .valid_i       (validM_i),
        .pc_i          (pcM_i),
        .aluout_i      (aluoutM_i),
        .writereg_i    (writeregM_i),
        .regwrite_i    (regwriteM_i),
        .insnExc_i     (insnExc),
        .insnCode_i    (insnCode),
        .insnBadAddr_i (insnBadAddr),
        .lane          (laneBus.dst),
        .memEn_o       (memEn_o),
        .memWen_o      (memWen_o),
        .memWdata_o    (memWdata_o),
        .resultW_o     (resultW_o),
        .writeregW_o   (writeregW_o),
        .regwriteW_o   (regwriteW_o),
        .exceptW_o     (exceptW_o),
        .excCodeW_o    (excCodeW_o),
        .epcW_o        (epcW_o),
        .badVaddrW_o   (badVaddrW_o)
    );

endmodule

// File: logic/memStagePkg.sv
package memStagePkg;

    localparam int dataW    = 32;
    localparam int regAddrW = 5;
    localparam int laneN    = 4;
    localparam int excCodeW = 5;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLh      = 6'h21;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opLbu     = 6'h24;
    localparam logic [5:0] opLhu     = 6'h25;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSh      = 6'h29;
    localparam logic [5:0] opSw      = 6'h2b;

    localparam logic [5:0] fnSyscall = 6'h0c; // funct under SPECIAL
    localparam logic [5:0] fnBreak   = 6'h0d;

    // cause register ExcCode values
    localparam logic [excCodeW-1:0] excAdel = 5'd4;
    localparam logic [excCodeW-1:0] excAdes = 5'd5;
    localparam logic [excCodeW-1:0] excSys  = 5'd8;
    localparam logic [excCodeW-1:0] excBp   = 5'd9;
    localparam logic [excCodeW-1:0] excOv   = 5'd12;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  base;
        logic [4:0]  rt;
        logic [15:0] offset;
    } iTypeT;

    // one instruction word, read as R-type or I-type
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

endpackage

// File: src.f
+incdir+include
logic/memStagePkg.sv
logic/memLaneIf.sv
logic/memLane.sv
logic/exceptDetect.sv
logic/memCommit.sv
logic/memStage.sv
bench/memStageTb.sv
